//--- ll_link_pkg.sv
/*
  Link-layer definitions for the chiplet AXI-stream receive path.
  Holds the PHY word bit layouts for gen1 and gen2, the auto-sync
  state encoding and the receive debug status word. Compile before
  any module that imports it.
*/
`default_nettype none

package ll_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // PHY word geometry

  localparam int LL_PHY_W      = 80;
  // Stream entry plus push bit
  localparam int LL_PAYLOAD_W  = 74;
  localparam int LL_PUSH_BIT   = 73;
  // Credit return on the transmit word, same in both layouts
  localparam int LL_CREDIT_BIT = 0;

  // Gen2: payload packed from bit 0, user bits at the top
  localparam int GEN2_STB_BIT  = 78;
  localparam int GEN2_MRK_BIT  = 79;

  // Gen1: payload split around the strobe and marker
  localparam int GEN1_LO_W     = 38;
  localparam int GEN1_STB_BIT  = 38;
  localparam int GEN1_MRK_BIT  = 39;
  localparam int GEN1_HI_LSB   = 40;
  localparam int GEN1_HI_W     = LL_PAYLOAD_W - GEN1_LO_W;

  //////////////////////////////////////////////////////////////////////
  // Auto-sync and debug

  // Link bring-up sequence
  typedef enum logic [1:0] {
    SYNC_IDLE    = 2'd0,
    SYNC_TX_WAIT = 2'd1,
    SYNC_RX_WAIT = 2'd2,
    SYNC_ONLINE  = 2'd3
  } sync_state_t;

  // Receive debug word, msb first
  typedef struct packed {
    sync_state_t sync_state;   // [31:30]
    logic [4:0]  reserved;     // [29:25]
    logic        overflow;     // [24] sticky
    logic [15:0] push_count;   // [23:8] wraps
    logic [7:0]  occupancy;    // [7:0]
  } rx_debug_t;

endpackage

`default_nettype wire

//--- axi_st_pkg.sv
/*
  AXI-stream beat definition for the 64-bit user port.
  The same 73-bit beat is the FIFO entry, the PHY payload
  and the registered user beat.
*/
`default_nettype none

package axi_st_pkg;

  localparam int ST_KEEP_W = 8;
  localparam int ST_DATA_W = 64;

  // Field order sets the PHY bit order, tlast lands in bit 0
  typedef struct packed {
    logic [ST_KEEP_W-1:0] tkeep;
    logic [ST_DATA_W-1:0] tdata;
    logic                 tlast;
  } st_beat_t;

  // 73 bits
  localparam int ST_BEAT_W = $bits(st_beat_t);

endpackage

`default_nettype wire

//--- ll_auto_sync.sv
/*
  Link bring-up sequencer. Delays tx_online by delay_x_value cycles
  and rx_online by a further delay_y_value cycles, and drives the
  strobe and marker user bits during the sync window, i.e. while
  tx_online is up but tx_online_delay is not yet.
*/
`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync (
  input  logic                     clk_wr,
  input  logic                     reset,
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic [15:0]              delay_x_value,
  input  logic [15:0]              delay_y_value,
  input  logic [15:0]              delay_z_value,
  input  logic                     tx_mrk_userbit,
  input  logic                     tx_stb_userbit,
  output logic                     tx_online_delay,
  output logic                     rx_online_delay,
  output logic                     tx_auto_mrk_userbit,
  output logic                     tx_auto_stb_userbit,
  output ll_link_pkg::sync_state_t sync_state
);
  import ll_link_pkg::*;

  sync_state_t state_q;
  sync_state_t state_d;
  logic [15:0] dly_cnt_q;
  logic [15:0] dly_cnt_d;
  logic [15:0] stb_cnt_q;
  logic        sync_window;

  //////////////////////////////////////////////////////////////////////
  // Online FSM

  // One counter, reused for the tx and the rx wait
  always_comb begin
    state_d   = state_q;
    dly_cnt_d = dly_cnt_q;
    case (state_q)
      SYNC_IDLE, SYNC_TX_WAIT: begin
        if (!tx_online) begin
          state_d   = SYNC_IDLE;
          dly_cnt_d = '0;
        end else if (dly_cnt_q >= delay_x_value) begin
          state_d   = SYNC_RX_WAIT;
          dly_cnt_d = '0;
        end else begin
          state_d   = SYNC_TX_WAIT;
          dly_cnt_d = dly_cnt_q + 16'd1;
        end
      end
      SYNC_RX_WAIT: begin
        if (!tx_online) begin
          state_d   = SYNC_IDLE;
          dly_cnt_d = '0;
        end else if (!rx_online) begin
          // Restart the rx delay whenever rx drops
          dly_cnt_d = '0;
        end else if (dly_cnt_q >= delay_y_value) begin
          state_d   = SYNC_ONLINE;
          dly_cnt_d = '0;
        end else begin
          dly_cnt_d = dly_cnt_q + 16'd1;
        end
      end
      SYNC_ONLINE: begin
        dly_cnt_d = '0;
        if (!tx_online) begin
          state_d = SYNC_IDLE;
        end else if (!rx_online) begin
          state_d = SYNC_RX_WAIT;
        end
      end
      default: begin
        state_d   = SYNC_IDLE;
        dly_cnt_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state_q   <= SYNC_IDLE;
      dly_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      dly_cnt_q <= dly_cnt_d;
    end
  end

  assign tx_online_delay = (state_q == SYNC_RX_WAIT) || (state_q == SYNC_ONLINE);
  assign rx_online_delay = (state_q == SYNC_ONLINE);
  assign sync_state      = state_q;

  //////////////////////////////////////////////////////////////////////
  // Sync window user bits

  assign sync_window = tx_online && !tx_online_delay;

  // Strobe period counter, 0 .. delay_z_value-1
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      stb_cnt_q <= '0;
    end else if (!sync_window) begin
      stb_cnt_q <= '0;
    end else if (stb_cnt_q + 16'd1 >= delay_z_value) begin
      stb_cnt_q <= '0;
    end else begin
      stb_cnt_q <= stb_cnt_q + 16'd1;
    end
  end

  // First window cycle carries a strobe
  assign tx_auto_stb_userbit = sync_window && tx_stb_userbit && (stb_cnt_q == '0);
  assign tx_auto_mrk_userbit = sync_window && tx_mrk_userbit;

  // Receive side never comes up ahead of transmit
  a_rx_after_tx : assert property (
    @(posedge clk_wr) disable iff (reset) rx_online_delay |-> tx_online_delay
  ) else $error("ll_auto_sync: rx_online_delay high with tx_online_delay low");

endmodule

`default_nettype wire

//--- ll_receive.sv
/*
  Credit-managed receive FIFO. Pushes from the PHY are taken only while
  rx_online is high, the head entry is offered to the user register, and
  every pop returns one credit while tx_online is high. Also builds the
  32-bit debug status word. DEPTH must be a power of two, at most 128.
*/
`timescale 1ns/1ps
`default_nettype none

module ll_receive #(
  parameter int DEPTH = 128
) (
  input  logic                     clk_wr,
  input  logic                     reset,
  input  logic                     rx_online,
  input  logic                     tx_online,
  input  ll_link_pkg::sync_state_t sync_state,
  input  axi_st_pkg::st_beat_t     rx_i_data,
  input  logic                     rx_i_pushbit,
  input  logic                     user_i_ready,
  output axi_st_pkg::st_beat_t     rxfifo_i_data,
  output logic                     user_i_valid,
  output logic                     tx_i_credit,
  output ll_link_pkg::rx_debug_t   rx_i_debug_status
);
  import axi_st_pkg::*;

  localparam int AW = $clog2(DEPTH);

  st_beat_t      fifo_mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          full;
  logic          empty;
  logic          push_req;
  logic          do_push;
  logic          pop;
  logic          overflow_q;
  logic [15:0]   push_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // FIFO control

  // Power-of-two depth, top count bit alone means full
  assign full  = count_q[AW];
  assign empty = (count_q == '0);

  // Early pushes are dropped until rx is online
  assign push_req = rx_i_pushbit && rx_online;
  assign do_push  = push_req && !full;

  assign user_i_valid  = !empty;
  assign pop           = user_i_valid && user_i_ready;
  assign rxfifo_i_data = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk_wr) begin
    if (do_push) begin
      fifo_mem[wr_ptr_q] <= rx_i_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credit return and status

  // One credit per popped entry, a cycle after the pop
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_i_credit <= 1'b0;
      overflow_q  <= 1'b0;
      push_cnt_q  <= '0;
    end else begin
      tx_i_credit <= pop && tx_online;
      if (push_req && full) begin
        overflow_q <= 1'b1;
      end
      if (do_push) begin
        push_cnt_q <= push_cnt_q + 16'd1;
      end
    end
  end

  always_comb begin
    rx_i_debug_status            = '0;
    rx_i_debug_status.sync_state = sync_state;
    rx_i_debug_status.overflow   = overflow_q;
    rx_i_debug_status.push_count = push_cnt_q;
    rx_i_debug_status.occupancy  = 8'(count_q);
  end

  // Remote side ran past its credits
  a_no_push_full : assert property (
    @(posedge clk_wr) disable iff (reset) push_req |-> !full
  ) else $error("ll_receive: push into a full FIFO, credits out of step");

  // Pop from empty would wrap the count past DEPTH
  a_count_range : assert property (
    @(posedge clk_wr) disable iff (reset) count_q <= DEPTH
  ) else $error("ll_receive: occupancy out of range, pop from an empty FIFO");

endmodule

`default_nettype wire

//--- axi_st_d64_slave_concat.sv
/*
  PHY word packing for the stream slave. Unpacks the registered receive
  word into a stream entry and push bit, and packs the credit, strobe
  and marker into the registered transmit word. m_gen2_mode picks the
  gen2 or the gen1 bit layout.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_st_d64_slave_concat (
  input  logic                             clk_wr,
  input  logic                             reset,
  input  logic                             m_gen2_mode,
  input  logic                             tx_online,
  input  logic                             tx_st_credit,
  input  logic                             tx_stb_userbit,
  input  logic                             tx_mrk_userbit,
  input  logic [ll_link_pkg::LL_PHY_W-1:0] rx_phy0,
  output logic [ll_link_pkg::LL_PHY_W-1:0] tx_phy0,
  output axi_st_pkg::st_beat_t             rx_st_data,
  output logic                             rx_st_pushbit
);
  import ll_link_pkg::*;
  import axi_st_pkg::*;

  logic [LL_PAYLOAD_W-1:0] rx_payload;
  logic [LL_PHY_W-1:0]     tx_word;

  //////////////////////////////////////////////////////////////////////
  // Receive unpack

  // Gen1 payload skips the strobe and marker at 38 and 39
  always_comb begin
    if (m_gen2_mode) begin
      rx_payload = rx_phy0[LL_PAYLOAD_W-1:0];
    end else begin
      rx_payload = {rx_phy0[GEN1_HI_LSB +: GEN1_HI_W], rx_phy0[GEN1_LO_W-1:0]};
    end
  end

  // Entry is payload only
  always_ff @(posedge clk_wr) begin
    rx_st_data <= st_beat_t'(rx_payload[ST_BEAT_W-1:0]);
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_st_pushbit <= 1'b0;
    end else begin
      rx_st_pushbit <= rx_payload[LL_PUSH_BIT];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit pack

  // No tx data path, all other bits stay 0
  always_comb begin
    tx_word                = '0;
    tx_word[LL_CREDIT_BIT] = tx_st_credit && tx_online;
    if (m_gen2_mode) begin
      tx_word[GEN2_STB_BIT] = tx_stb_userbit;
      tx_word[GEN2_MRK_BIT] = tx_mrk_userbit;
    end else begin
      tx_word[GEN1_STB_BIT] = tx_stb_userbit;
      tx_word[GEN1_MRK_BIT] = tx_mrk_userbit;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

endmodule

`default_nettype wire

//--- axi_st_d64_slave_name.sv
/*
  User-side output register. Takes the FIFO head whenever the register
  is empty or its beat is being accepted, and drives the AXI-stream
  tkeep, tdata, tlast and tvalid ports from it.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_st_d64_slave_name (
  input  logic                                clk_wr,
  input  logic                                reset,
  input  logic                                user_st_vld,
  input  axi_st_pkg::st_beat_t                rxfifo_st_data,
  input  logic                                user_tready,
  output logic                                user_st_ready,
  output logic [axi_st_pkg::ST_KEEP_W-1:0]    user_tkeep,
  output logic [axi_st_pkg::ST_DATA_W-1:0]    user_tdata,
  output logic                                user_tlast,
  output logic                                user_tvalid
);
  import axi_st_pkg::*;

  st_beat_t beat_q;
  logic     valid_q;
  logic     load;

  // Free slot now or drained this cycle
  assign user_st_ready = !valid_q || user_tready;
  assign load          = user_st_vld && user_st_ready;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (user_tready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (load) begin
      beat_q <= rxfifo_st_data;
    end
  end

  assign user_tvalid = valid_q;
  assign user_tkeep  = beat_q.tkeep;
  assign user_tdata  = beat_q.tdata;
  assign user_tlast  = beat_q.tlast;

  // Stalled beat holds until accepted
  a_beat_stable : assert property (
    @(posedge clk_wr) disable iff (reset)
    user_tvalid && !user_tready |=> user_tvalid && $stable({user_tkeep, user_tdata, user_tlast})
  ) else $error("axi_st_d64_slave_name: beat changed while stalled");

endmodule

`default_nettype wire

//--- axi_st_d64_slave_top.sv
/*
  Receive-only AXI-stream slave over a die-to-die PHY link.
  PHY words enter through concat, are buffered in the receive FIFO and
  leave as 64-bit AXI-stream beats, and popped entries return credits
  on tx_phy0. Auto-sync gates both directions during bring-up.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_st_d64_slave_top #(
  parameter int FIFO_DEPTH = 128
) (
  input  logic        clk_wr,
  input  logic        reset,

  // Link control
  input  logic        tx_online,
  input  logic        rx_online,

  // PHY side
  output logic [79:0] tx_phy0,
  input  logic [79:0] rx_phy0,

  // AXI-stream master port to user
  output logic [7:0]  user_tkeep,
  output logic [63:0] user_tdata,
  output logic        user_tlast,
  output logic        user_tvalid,
  input  logic        user_tready,

  output logic [31:0] rx_st_debug_status,

  // Configuration
  input  logic        m_gen2_mode,
  input  logic        tx_mrk_userbit,
  input  logic        tx_stb_userbit,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [15:0] delay_z_value
);
  import ll_link_pkg::*;
  import axi_st_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  st_beat_t    rx_st_data;
  st_beat_t    rxfifo_st_data;
  logic        rx_st_pushbit;
  logic        user_st_vld;
  logic        user_st_ready;
  logic        tx_st_credit;
  logic        tx_online_delay;
  logic        rx_online_delay;
  logic        tx_auto_mrk_userbit;
  logic        tx_auto_stb_userbit;
  sync_state_t sync_state;

  //////////////////////////////////////////////////////////////////////
  // Blocks

  ll_auto_sync ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .reset               (reset),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .sync_state          (sync_state)
  );

  // FIFO sees the delayed online levels
  ll_receive #(
    .DEPTH (FIFO_DEPTH)
  ) ll_receive_i (
    .clk_wr            (clk_wr),
    .reset             (reset),
    .rx_online         (rx_online_delay),
    .tx_online         (tx_online_delay),
    .sync_state        (sync_state),
    .rx_i_data         (rx_st_data),
    .rx_i_pushbit      (rx_st_pushbit),
    .user_i_ready      (user_st_ready),
    .rxfifo_i_data     (rxfifo_st_data),
    .user_i_valid      (user_st_vld),
    .tx_i_credit       (tx_st_credit),
    .rx_i_debug_status (rx_st_debug_status)
  );

  axi_st_d64_slave_name axi_st_d64_slave_name_i (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .user_st_vld    (user_st_vld),
    .rxfifo_st_data (rxfifo_st_data),
    .user_tready    (user_tready),
    .user_st_ready  (user_st_ready),
    .user_tkeep     (user_tkeep),
    .user_tdata     (user_tdata),
    .user_tlast     (user_tlast),
    .user_tvalid    (user_tvalid)
  );

  axi_st_d64_slave_concat axi_st_d64_slave_concat_i (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .m_gen2_mode    (m_gen2_mode),
    .tx_online      (tx_online_delay),
    .tx_st_credit   (tx_st_credit),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .rx_phy0        (rx_phy0),
    .tx_phy0        (tx_phy0),
    .rx_st_data     (rx_st_data),
    .rx_st_pushbit  (rx_st_pushbit)
  );

endmodule

`default_nettype wire

//--- tb_axi_st_checker.sv
/*
  Scoreboard for the stream slave testbench. Follows the link bring-up
  from the control inputs, predicts user beats from the PHY words seen
  on rx_phy0, and compares beats, stalled beats, tx user bits, credits
  and the debug word. Counts errors on its errors output.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_axi_st_checker #(
  parameter int NAME_W = 192
) (
  input  logic              clk_wr,
  input  logic              reset,
  input  logic [NAME_W-1:0] test_name,
  input  logic              final_check,
  input  logic              tx_online,
  input  logic              rx_online,
  input  logic              m_gen2_mode,
  input  logic              tx_mrk_userbit,
  input  logic              tx_stb_userbit,
  input  logic [15:0]       delay_x_value,
  input  logic [15:0]       delay_y_value,
  input  logic [15:0]       delay_z_value,
  input  logic [79:0]       rx_phy0,
  input  logic [79:0]       tx_phy0,
  input  logic [7:0]        user_tkeep,
  input  logic [63:0]       user_tdata,
  input  logic              user_tlast,
  input  logic              user_tvalid,
  input  logic              user_tready,
  input  logic [31:0]       rx_st_debug_status,
  output int                errors,
  output int                accepted
);
  import ll_link_pkg::*;
  import axi_st_pkg::*;

  st_beat_t                exp_q [$];
  st_beat_t                got;
  st_beat_t                held;
  st_beat_t                want;
  rx_debug_t               dbg;
  logic                    held_vld;
  logic                    rst_prev;
  logic                    tx_dly;
  logic                    rx_dly;
  logic                    win;
  logic [LL_PHY_W-1:0]     exp_tx;
  logic [LL_PAYLOAD_W-1:0] payload;
  int                      tx_hi_cnt;
  int                      both_cnt;
  int                      stb_cnt;
  int                      credits;
  int                      pushes;

  assign got = {user_tkeep, user_tdata, user_tlast};
  assign dbg = rx_st_debug_status;

  initial begin
    errors    = 0;
    accepted  = 0;
    credits   = 0;
    pushes    = 0;
    tx_hi_cnt = 0;
    both_cnt  = 0;
    stb_cnt   = 0;
    held_vld  = 1'b0;
    rst_prev  = 1'b0;
    exp_tx    = '0;
  end

  task automatic report_mismatch(input string what, input logic [79:0] exp_v,
                                 input logic [79:0] act_v);
    errors++;
    $display("** Error [%0s] %0s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Error in test %0s: %0s", test_name, msg);
  endtask

  // Payload bit by bit, gen1 steps over the strobe and marker at 38 and 39
  function automatic logic [LL_PAYLOAD_W-1:0] phy_payload(input logic gen2,
                                                          input logic [LL_PHY_W-1:0] w);
    logic [LL_PAYLOAD_W-1:0] p;
    int                      j;
    for (j = 0; j < LL_PAYLOAD_W; j++) begin
      p[j] = (gen2 || j < GEN1_STB_BIT) ? w[j] : w[j + 2];
    end
    return p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Per-cycle compare, then the model steps over this edge

  always @(posedge clk_wr) begin
    if (reset) begin
      if (rst_prev && (user_tvalid || tx_phy0 != '0 || dbg.occupancy != 8'd0)) begin
        report_failure("outputs not cleared while reset is held");
      end
      rst_prev  = 1'b1;
      tx_hi_cnt = 0;
      both_cnt  = 0;
      stb_cnt   = 0;
      held_vld  = 1'b0;
      exp_tx    = '0;
    end else begin
      rst_prev = 1'b0;
      tx_dly   = tx_hi_cnt > delay_x_value;
      rx_dly   = both_cnt > delay_y_value;

      // Strobe and marker registered at the last edge
      if (tx_phy0[LL_PHY_W-1:1] != exp_tx[LL_PHY_W-1:1]) begin
        report_mismatch("tx_phy0 user bits", exp_tx, tx_phy0);
      end
      if ((dbg.sync_state inside {SYNC_RX_WAIT, SYNC_ONLINE}) != tx_dly ||
          (dbg.sync_state == SYNC_ONLINE) != rx_dly) begin
        report_mismatch("online delays", {tx_dly, rx_dly}, dbg.sync_state);
      end
      if (tx_phy0[LL_CREDIT_BIT]) begin
        credits++;
      end

      // Stalled beat must still be there, unchanged
      if (held_vld && (!user_tvalid || got != held)) begin
        report_mismatch("stalled beat", held, got);
      end
      held_vld = user_tvalid && !user_tready;
      held     = got;

      if (user_tvalid && user_tready) begin
        accepted++;
        if (exp_q.size() == 0) begin
          report_failure("beat accepted with no pushed word outstanding");
        end else begin
          want = exp_q.pop_front();
          if (got != want) begin
            report_mismatch("user beat", want, got);
          end
        end
      end

      // Sync window, strobe on every delay_z_value-th cycle from its start
      win    = tx_online && !tx_dly;
      exp_tx = '0;
      if (win) begin
        exp_tx[m_gen2_mode ? GEN2_STB_BIT : GEN1_STB_BIT] =
          tx_stb_userbit && (delay_z_value <= 16'd1 || stb_cnt % delay_z_value == 0);
        exp_tx[m_gen2_mode ? GEN2_MRK_BIT : GEN1_MRK_BIT] = tx_mrk_userbit;
      end
      stb_cnt   = win ? stb_cnt + 1 : 0;
      both_cnt  = (tx_online && tx_dly && rx_online) ? both_cnt + 1 : 0;
      tx_hi_cnt = tx_online ? tx_hi_cnt + 1 : 0;
      rx_dly    = both_cnt > delay_y_value;

      // Word taken by concat now reaches the FIFO with this rx level
      payload = phy_payload(m_gen2_mode, rx_phy0);
      if (payload[LL_PUSH_BIT] && rx_dly) begin
        exp_q.push_back(st_beat_t'(payload[ST_BEAT_W-1:0]));
        pushes++;
      end

      if (final_check) begin
        if (exp_q.size() != 0) begin
          report_failure("pushed words never arrived on the user port");
        end
        if (credits != accepted) begin
          report_mismatch("credit count", accepted, credits);
        end
        if (dbg.push_count != pushes[15:0]) begin
          report_mismatch("debug push count", pushes[15:0], dbg.push_count);
        end
        if (dbg.occupancy != 8'd0) begin
          report_mismatch("idle occupancy", 0, dbg.occupancy);
        end
        if (dbg.overflow) begin
          report_failure("FIFO overflow flagged in debug status");
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_axi_st_slave.sv
/*
  Testbench for the receive-side AXI-stream slave. Brings the link up
  in gen1 layout with pushed words that must be dropped, then runs a
  table of tests in gen1 and gen2 layout under returned credits and a
  random tready. All comparing happens in the checker instance.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_axi_st_slave;
  import ll_link_pkg::*;
  import axi_st_pkg::*;

  localparam int FIFO_DEPTH  = 16;
  localparam int NAME_W      = 8 * 24;
  localparam int NUM_TESTS   = 5;
  localparam int DELAY_X     = 20;
  localparam int DELAY_Y     = 6;
  localparam int DELAY_Z     = 4;
  localparam int EARLY_WORDS = 10;

  // One row of the stimulus table
  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic              gen2;
    logic [15:0]       nbeats;
    logic [7:0]        duty;
    logic [63:0]       base;
  } test_row_t;

  logic              clk_wr = 1'b0;
  logic              reset;
  logic              tx_online;
  logic              rx_online;
  logic [79:0]       rx_phy0;
  logic [79:0]       tx_phy0;
  logic [7:0]        user_tkeep;
  logic [63:0]       user_tdata;
  logic              user_tlast;
  logic              user_tvalid;
  logic              user_tready;
  logic [31:0]       rx_st_debug_status;
  logic              m_gen2_mode;
  logic              tx_mrk_userbit;
  logic              tx_stb_userbit;
  logic [15:0]       delay_x_value;
  logic [15:0]       delay_y_value;
  logic [15:0]       delay_z_value;
  logic [NAME_W-1:0] cur_name;
  logic              final_check;
  int                errors;
  int                accepted;
  test_row_t         tests [NUM_TESTS];
  integer            seed;
  int                ready_duty;
  int                sent_cnt;
  int                credits_back;
  int                limit_cycles;
  int                total_beats;

  // 100 ns clock
  always #50 clk_wr = ~clk_wr;

  axi_st_d64_slave_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .rx_st_debug_status (rx_st_debug_status),
    .m_gen2_mode        (m_gen2_mode),
    .tx_mrk_userbit     (tx_mrk_userbit),
    .tx_stb_userbit     (tx_stb_userbit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value)
  );

  tb_axi_st_checker #(
    .NAME_W (NAME_W)
  ) stream_check (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .test_name          (cur_name),
    .final_check        (final_check),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .m_gen2_mode        (m_gen2_mode),
    .tx_mrk_userbit     (tx_mrk_userbit),
    .tx_stb_userbit     (tx_stb_userbit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value),
    .rx_phy0            (rx_phy0),
    .tx_phy0            (tx_phy0),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .rx_st_debug_status (rx_st_debug_status),
    .errors             (errors),
    .accepted           (accepted)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic st_beat_t make_beat(input logic [63:0] base, input int idx, input int n);
    st_beat_t b;
    b.tkeep = (idx == n - 1) ? 8'h0f : 8'hff;
    b.tdata = base + 64'(idx) * 64'h0000_0101_0000_0001;
    b.tlast = (idx % 8 == 7) || (idx == n - 1);
    return b;
  endfunction

  // Entry plus push bit placed by the package layout
  function automatic logic [LL_PHY_W-1:0] pack_word(input logic gen2, input st_beat_t b);
    logic [LL_PAYLOAD_W-1:0] payload;
    logic [LL_PHY_W-1:0]     w;
    payload                  = '0;
    payload[ST_BEAT_W-1:0]   = b;
    payload[LL_PUSH_BIT]     = 1'b1;
    w                        = '0;
    if (gen2) begin
      w[LL_PAYLOAD_W-1:0] = payload;
    end else begin
      w[GEN1_LO_W-1:0]            = payload[GEN1_LO_W-1:0];
      w[GEN1_HI_LSB +: GEN1_HI_W] = payload[LL_PAYLOAD_W-1:GEN1_LO_W];
    end
    return w;
  endfunction

  task automatic add_row(input int k, input logic [NAME_W-1:0] name, input logic gen2,
                         input int n, input int duty, input logic [63:0] base);
    tests[k].name   = name;
    tests[k].gen2   = gen2;
    tests[k].nbeats = 16'(n);
    tests[k].duty   = 8'(duty);
    tests[k].base   = base;
  endtask

  // Sends one row as credits allow, then waits for the stream to drain
  task automatic run_row(input test_row_t row);
    int i;
    i = 0;
    @(posedge clk_wr);
    cur_name    <= row.name;
    m_gen2_mode <= row.gen2;
    ready_duty  <= row.duty;
    while (i < row.nbeats) begin
      @(posedge clk_wr);
      if (sent_cnt - credits_back < FIFO_DEPTH) begin
        rx_phy0  <= pack_word(row.gen2, make_beat(row.base, i, row.nbeats));
        sent_cnt = sent_cnt + 1;
        i++;
      end else begin
        rx_phy0 <= '0;
      end
    end
    @(posedge clk_wr);
    rx_phy0 <= '0;
    // Accepted count settles between edges
    while (accepted < sent_cnt) begin
      @(negedge clk_wr);
    end
    // Room for the last credit to come back
    repeat (4) @(posedge clk_wr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random tready and marker, credit return count

  always @(posedge clk_wr) begin
    user_tready    <= ($unsigned($random(seed)) % 100) < ready_duty;
    tx_mrk_userbit <= $random(seed) & 1;
  end

  always @(posedge clk_wr) begin
    if (reset) begin
      credits_back <= 0;
    end else if (tx_phy0[LL_CREDIT_BIT]) begin
      credits_back <= credits_back + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    int k;
    reset          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    rx_phy0        = '0;
    user_tready    = 1'b0;
    m_gen2_mode    = 1'b0;
    tx_mrk_userbit = 1'b0;
    tx_stb_userbit = 1'b1;
    delay_x_value  = 16'(DELAY_X);
    delay_y_value  = 16'(DELAY_Y);
    delay_z_value  = 16'(DELAY_Z);
    cur_name       = "link_bring_up";
    final_check    = 1'b0;
    seed           = 32'h2999fe98;
    ready_duty     = 100;
    sent_cnt       = 0;

    add_row(0, "gen2_full_ready",   1'b1,  24, 100, 64'h0123_4567_0000_0000);
    add_row(1, "gen1_full_ready",   1'b0,  24, 100, 64'h89ab_cdef_0000_0000);
    add_row(2, "gen2_random_ready", 1'b1,  40,  50, 64'h5a5a_0000_1000_0000);
    add_row(3, "gen1_random_ready", 1'b0,  40,  30, 64'ha5a5_0000_2000_0000);
    add_row(4, "gen2_backpressure", 1'b1, 160,  25, 64'hc3c3_0000_3000_0000);
    total_beats = 0;
    for (k = 0; k < NUM_TESTS; k++) begin
      total_beats += tests[k].nbeats;
    end
    limit_cycles = (total_beats + DELAY_X + DELAY_Y + DELAY_Z + EARLY_WORDS) * 20;

    repeat (5) @(posedge clk_wr);
    reset <= 1'b0;
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    // Pushed words ahead of rx_online_delay, all dropped
    for (k = 0; k < EARLY_WORDS; k++) begin
      @(posedge clk_wr);
      rx_phy0 <= pack_word(1'b0, make_beat(64'hbad0_0000_0000_0000, k, EARLY_WORDS));
    end
    @(posedge clk_wr);
    rx_phy0 <= '0;
    while (rx_st_debug_status[31:30] != SYNC_ONLINE) begin
      @(posedge clk_wr);
    end

    for (k = 0; k < NUM_TESTS; k++) begin
      run_row(tests[k]);
    end

    @(posedge clk_wr);
    final_check <= 1'b1;
    @(posedge clk_wr);
    final_check <= 1'b0;
    @(negedge clk_wr);
    $display("Run complete: %0d beats checked, %0d errors", accepted, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the table and the link delays
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_wr);
    $display("Watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
ll_link_pkg.sv
axi_st_pkg.sv
ll_auto_sync.sv
ll_receive.sv
axi_st_d64_slave_concat.sv
axi_st_d64_slave_name.sv
axi_st_d64_slave_top.sv
tb_axi_st_checker.sv
tb_axi_st_slave.sv

//--- Bender.yml
package:
  name: axi_st_d64_slave

sources:
  - ll_link_pkg.sv
  - axi_st_pkg.sv
  - ll_auto_sync.sv
  - ll_receive.sv
  - axi_st_d64_slave_concat.sv
  - axi_st_d64_slave_name.sv
  - axi_st_d64_slave_top.sv
  - target: test
    files:
      - tb_axi_st_checker.sv
      - tb_axi_st_slave.sv
